// ==== hdl/dispatch_router.sv ====
`timescale 1ns/1ps

module dispatch_router
(
	input isa_pkg::instr_u instr,
	input isa_pkg::word_t curr_pc,
	input logic dispatch_ok,
	input logic ldi_second,
	input tomasulo_pkg::rob_tag_t ldi_tag,
	input logic [tomasulo_pkg::num_alu_stations-1:0] alu_busy,
	input tomasulo_pkg::rob_tag_t rob_addr,
	input tomasulo_pkg::cdb_t cdb,
	operand_if.consumer src_a,
	operand_if.consumer src_b,
	input logic predict_bit,
	output tomasulo_pkg::station_id_t res_station_id,
	output isa_pkg::opcode_t res_op,
	output isa_pkg::word_t res_vj,
	output isa_pkg::word_t res_vk,
	output tomasulo_pkg::rob_tag_t res_qj,
	output tomasulo_pkg::rob_tag_t res_qk,
	output logic issue_ld_vj,
	output logic issue_ld_vk,
	output logic issue_ld_qj,
	output logic issue_ld_qk,
	output logic issue_ld_busy_dest,
	output logic ldstr_write_enable,
	output isa_pkg::word_t ldstr_offset,
	output isa_pkg::word_t ldstr_vbase,
	output logic ldstr_vbase_valid,
	output tomasulo_pkg::rob_tag_t ldstr_qbase,
	output isa_pkg::word_t ldstr_vsrc,
	output logic ldstr_vsrc_valid,
	output tomasulo_pkg::rob_tag_t ldstr_qsrc,
	output tomasulo_pkg::rob_tag_t ldstr_dest,
	output logic rob_write_enable,
	output isa_pkg::reg_idx_t rob_dest,
	output isa_pkg::word_t rob_value,
	output isa_pkg::reg_idx_t reg_dest,
	output logic ld_reg_busy_dest,
	output tomasulo_pkg::rob_tag_t reg_rob_entry,
	output logic pcmux_sel,
	output isa_pkg::word_t br_pc
);
	import isa_pkg::*;
	import tomasulo_pkg::*;

	opcode_t op;
	reg_idx_t dr;
	logic [5:0] off6;
	word_t sext5;
	word_t sext6;
	word_t adj6;
	word_t adj9;
	word_t pc_target;
	station_id_t free_id;
	logic ldi_hit;

	assign op = instr.opr.opcode;
	assign dr = instr.opr.dr;
	assign off6 = instr.off.off9[5:0];

	assign sext5 = {{11{instr.opr.imm_sr2[4]}}, instr.opr.imm_sr2};
	assign sext6 = {{10{off6[5]}}, off6};    // Byte offset for LDB/STB
	assign adj6 = {{9{off6[5]}}, off6, 1'b0};
	assign adj9 = {{6{instr.off.off9[8]}}, instr.off.off9, 1'b0};
	assign pc_target = curr_pc + adj9;

	assign ldi_hit = cdb.valid && (cdb.tag == ldi_tag);

	// Lowest-numbered free station
	always_comb
	begin
		free_id = '0;
		for (int i = num_alu_stations - 1; i >= 0; i--)
		begin
			if (!alu_busy[i])
				free_id = station_id_t'(i);
		end
	end

	always_comb
	begin
		res_station_id = '0;
		res_op = op_br;
		res_vj = '0;
		res_vk = '0;
		res_qj = '0;
		res_qk = '0;
		issue_ld_vj = 1'b0;
		issue_ld_vk = 1'b0;
		issue_ld_qj = 1'b0;
		issue_ld_qk = 1'b0;
		issue_ld_busy_dest = 1'b0;
		ldstr_write_enable = 1'b0;
		ldstr_offset = '0;
		ldstr_vbase = '0;
		ldstr_vbase_valid = 1'b0;
		ldstr_qbase = '0;
		ldstr_vsrc = '0;
		ldstr_vsrc_valid = 1'b0;
		ldstr_qsrc = '0;
		ldstr_dest = '0;
		rob_write_enable = 1'b0;
		rob_dest = '0;
		rob_value = '0;
		reg_dest = '0;
		ld_reg_busy_dest = 1'b0;
		reg_rob_entry = '0;
		pcmux_sel = 1'b0;
		br_pc = '0;
		if (dispatch_ok)
		begin
			case (op)
				op_add, op_and, op_not, op_shf:
				begin
					res_station_id = free_id;
					res_op = op;
					issue_ld_busy_dest = 1'b1;
					res_vj = src_a.value;
					res_qj = src_a.tag;
					issue_ld_vj = src_a.ready;
					issue_ld_qj = !src_a.ready;
					if (instr.opr.imm || op == op_shf) // Shift amount sits in the imm field
					begin
						res_vk = sext5;
						issue_ld_vk = 1'b1;
					end
					else
					begin
						res_vk = src_b.value;
						res_qk = src_b.tag;
						issue_ld_vk = src_b.ready;
						issue_ld_qk = !src_b.ready;
					end
					rob_write_enable = 1'b1;
					rob_dest = dr;
					reg_dest = dr;
					ld_reg_busy_dest = 1'b1;
					reg_rob_entry = rob_addr;
				end
				op_ldr, op_ldb:
				begin
					ldstr_write_enable = 1'b1;
					res_op = op;
					ldstr_offset = (op == op_ldr) ? adj6 : sext6;
					ldstr_vbase = src_a.value;
					ldstr_vbase_valid = src_a.ready;
					ldstr_qbase = src_a.tag;
					ldstr_dest = rob_addr;
					rob_write_enable = 1'b1;
					rob_dest = dr;
					reg_dest = dr;
					ld_reg_busy_dest = 1'b1;
					reg_rob_entry = rob_addr;
				end
				op_str, op_stb:
				begin
					ldstr_write_enable = 1'b1;
					res_op = op;
					ldstr_offset = (op == op_str) ? adj6 : sext6;
					ldstr_vbase = src_a.value;
					ldstr_vbase_valid = src_a.ready;
					ldstr_qbase = src_a.tag;
					ldstr_vsrc = src_b.value; // Store data comes from dr
					ldstr_vsrc_valid = src_b.ready;
					ldstr_qsrc = src_b.tag;
					rob_write_enable = 1'b1;
					reg_dest = dr;
				end
				op_ldi:
				begin
					ldstr_write_enable = 1'b1;
					res_op = op_ldr;
					ldstr_dest = rob_addr;
					rob_write_enable = 1'b1;
					rob_dest = dr;
					if (!ldi_second)
					begin
						// Pass 1 fetches the pointer
						ldstr_offset = adj6;
						ldstr_vbase = src_a.value;
						ldstr_vbase_valid = src_a.ready;
						ldstr_qbase = src_a.tag;
					end
					else
					begin
						if (ldi_hit)
						begin
							ldstr_vbase = cdb.data;
							ldstr_vbase_valid = 1'b1;
						end
						else
							ldstr_qbase = ldi_tag;
						reg_dest = dr;
						ld_reg_busy_dest = 1'b1;
						reg_rob_entry = rob_addr;
					end
				end
				op_br:
				begin
					rob_write_enable = 1'b1;
					rob_dest = dr;          // nzp bits
					br_pc = pc_target;
					if (predict_bit)
					begin
						rob_value = curr_pc; // Recovery PC if mispredicted
						pcmux_sel = 1'b1;
					end
					else
						rob_value = pc_target;
				end
				op_lea:
				begin
					rob_write_enable = 1'b1;
					rob_value = pc_target;
					rob_dest = dr;
					reg_dest = dr;
					ld_reg_busy_dest = 1'b1;
					reg_rob_entry = rob_addr;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

	localparam int reg_link = 7; // R7, also the highest register index

	typedef logic [15:0] word_t;
	typedef logic [$clog2(reg_link + 1)-1:0] reg_idx_t;

	// LC-3b encodings of the opcodes this stage handles
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_ldb = 4'b0010,
		op_stb = 4'b0011,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_ldi = 4'b1010,
		op_shf = 4'b1101,
		op_lea = 4'b1110
	} opcode_t;

	// ADD, AND, NOT, SHF
	typedef struct packed {
		opcode_t opcode;
		reg_idx_t dr;
		reg_idx_t sr1;
		logic imm;              // Bit 5
		logic [4:0] imm_sr2;    // imm5, or sr2 in the low bits
	} operate_t;

	// Loads, stores, BR and LEA
	typedef struct packed {
		opcode_t opcode;
		reg_idx_t dr;
		logic [8:0] off9;       // Base in [8:6], offset6 in [5:0]
	} offset_t;

	typedef union packed {
		operate_t opr;
		offset_t off;
	} instr_u;

endpackage

// ==== hdl/issue_sequencer.sv ====
`timescale 1ns/1ps

module issue_sequencer
(
	input logic clk,
	input logic rst,
	input logic flush,
	input logic instr_is_new,
	input isa_pkg::opcode_t opcode,
	input logic predict_bit,
	input logic rob_full,
	input logic ldstr_full,
	input logic alu_all_busy,
	input tomasulo_pkg::rob_tag_t rob_addr,
	output logic stall,
	output logic dispatch_ok,
	output logic ldi_second,
	output tomasulo_pkg::rob_tag_t ldi_tag
);
	import isa_pkg::*;

	typedef enum logic [1:0] {
		idle,
		ldi_wait,   // LDI pass 1 is out, pass 2 pending
		bubble      // Wrong-path slot after a predicted-taken branch
	} state_t;

	state_t state;
	state_t state_next;
	logic is_alu;
	logic is_mem;
	logic struct_stall;

	assign is_alu = (opcode == op_add) || (opcode == op_and) ||
		(opcode == op_not) || (opcode == op_shf);
	assign is_mem = (opcode == op_ldr) || (opcode == op_ldb) ||
		(opcode == op_str) || (opcode == op_stb) || (opcode == op_ldi);

	assign struct_stall = rob_full || (alu_all_busy && is_alu) || (ldstr_full && is_mem);

	assign dispatch_ok = instr_is_new && !struct_stall && (state != bubble);
	assign ldi_second = (state == ldi_wait);

	// Pass 1 of LDI holds fetch even when it dispatches
	assign stall = instr_is_new && (state != bubble) &&
		(struct_stall || (opcode == op_ldi && state == idle));

	always_comb
	begin
		state_next = state;
		case (state)
			idle:
			begin
				if (dispatch_ok && opcode == op_ldi)
					state_next = ldi_wait;
				else if (dispatch_ok && opcode == op_br && predict_bit)
					state_next = bubble;
			end
			ldi_wait:
			begin
				if (dispatch_ok) // Otherwise hold through back-pressure
					state_next = idle;
			end
			bubble: state_next = idle;
			default: state_next = idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst || flush)
			state <= idle;
		else
			state <= state_next;
	end

	// ROB entry of the pass 1 load, base for pass 2
	always_ff @(posedge clk)
	begin
		if (state == idle && dispatch_ok && opcode == op_ldi)
			ldi_tag <= rob_addr;
	end

endmodule

// ==== hdl/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage
(
	input logic clk,
	input logic rst,
	input logic flush,
	input isa_pkg::instr_u instr,
	input logic instr_is_new,
	input isa_pkg::word_t curr_pc,
	input logic predict_bit,
	input tomasulo_pkg::cdb_t cdb_in,
	input logic [tomasulo_pkg::num_alu_stations-1:0] alu_busy,
	input logic ldstr_full,
	input logic rob_full,
	input tomasulo_pkg::rob_tag_t rob_addr,
	input isa_pkg::word_t rob_sr1_value,
	input logic rob_sr1_valid,
	input isa_pkg::word_t rob_sr2_value,
	input logic rob_sr2_valid,
	input tomasulo_pkg::reg_lookup_t sr1_in,
	input tomasulo_pkg::reg_lookup_t sr2_in,
	input tomasulo_pkg::reg_lookup_t dest_in,
	output logic stall,
	output logic pcmux_sel,
	output isa_pkg::word_t br_pc,
	output tomasulo_pkg::station_id_t res_station_id,
	output isa_pkg::opcode_t res_op,
	output isa_pkg::word_t res_vj,
	output isa_pkg::word_t res_vk,
	output tomasulo_pkg::rob_tag_t res_qj,
	output tomasulo_pkg::rob_tag_t res_qk,
	output logic issue_ld_vj,
	output logic issue_ld_vk,
	output logic issue_ld_qj,
	output logic issue_ld_qk,
	output logic issue_ld_busy_dest,
	output logic ldstr_write_enable,
	output isa_pkg::word_t ldstr_offset,
	output isa_pkg::word_t ldstr_vbase,
	output logic ldstr_vbase_valid,
	output tomasulo_pkg::rob_tag_t ldstr_qbase,
	output isa_pkg::word_t ldstr_vsrc,
	output logic ldstr_vsrc_valid,
	output tomasulo_pkg::rob_tag_t ldstr_qsrc,
	output tomasulo_pkg::rob_tag_t ldstr_dest,
	output logic rob_write_enable,
	output isa_pkg::reg_idx_t rob_dest,
	output isa_pkg::word_t rob_value,
	output isa_pkg::reg_idx_t reg_dest,
	output logic ld_reg_busy_dest,
	output tomasulo_pkg::rob_tag_t reg_rob_entry,
	output isa_pkg::reg_idx_t sr1,
	output isa_pkg::reg_idx_t sr2,
	output tomasulo_pkg::rob_tag_t rob_sr1_read_addr,
	output tomasulo_pkg::rob_tag_t rob_sr2_read_addr
);
	import isa_pkg::*;
	import tomasulo_pkg::*;

	logic is_store;
	logic alu_all_busy;
	logic dispatch_ok;
	logic ldi_second;
	rob_tag_t ldi_tag;

	operand_if src_a();   // sr1 or base
	operand_if src_b();   // sr2 or store data

	assign is_store = (instr.opr.opcode == op_str) || (instr.opr.opcode == op_stb);
	assign alu_all_busy = &alu_busy;

	// Register file and ROB read addresses
	assign sr1 = instr.opr.sr1;
	assign sr2 = instr.opr.imm_sr2[2:0];
	assign rob_sr1_read_addr = sr1_in.rob_entry;
	assign rob_sr2_read_addr = is_store ? dest_in.rob_entry : sr2_in.rob_entry;

	assign src_a.lookup = sr1_in;
	assign src_a.rob_valid = rob_sr1_valid;
	assign src_a.rob_value = rob_sr1_value;
	assign src_b.lookup = is_store ? dest_in : sr2_in;
	assign src_b.rob_valid = rob_sr2_valid;
	assign src_b.rob_value = rob_sr2_value;

	operand_resolver i_resolve_a (.opnd(src_a), .cdb(cdb_in));
	operand_resolver i_resolve_b (.opnd(src_b), .cdb(cdb_in));

	issue_sequencer i_sequencer
	(
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.instr_is_new(instr_is_new),
		.opcode(instr.opr.opcode),
		.predict_bit(predict_bit),
		.rob_full(rob_full),
		.ldstr_full(ldstr_full),
		.alu_all_busy(alu_all_busy),
		.rob_addr(rob_addr),
		.stall(stall),
		.dispatch_ok(dispatch_ok),
		.ldi_second(ldi_second),
		.ldi_tag(ldi_tag)
	);

	dispatch_router i_router
	(
		.instr(instr),
		.curr_pc(curr_pc),
		.dispatch_ok(dispatch_ok),
		.ldi_second(ldi_second),
		.ldi_tag(ldi_tag),
		.alu_busy(alu_busy),
		.rob_addr(rob_addr),
		.cdb(cdb_in),
		.src_a(src_a),
		.src_b(src_b),
		.predict_bit(predict_bit),
		.res_station_id(res_station_id),
		.res_op(res_op),
		.res_vj(res_vj),
		.res_vk(res_vk),
		.res_qj(res_qj),
		.res_qk(res_qk),
		.issue_ld_vj(issue_ld_vj),
		.issue_ld_vk(issue_ld_vk),
		.issue_ld_qj(issue_ld_qj),
		.issue_ld_qk(issue_ld_qk),
		.issue_ld_busy_dest(issue_ld_busy_dest),
		.ldstr_write_enable(ldstr_write_enable),
		.ldstr_offset(ldstr_offset),
		.ldstr_vbase(ldstr_vbase),
		.ldstr_vbase_valid(ldstr_vbase_valid),
		.ldstr_qbase(ldstr_qbase),
		.ldstr_vsrc(ldstr_vsrc),
		.ldstr_vsrc_valid(ldstr_vsrc_valid),
		.ldstr_qsrc(ldstr_qsrc),
		.ldstr_dest(ldstr_dest),
		.rob_write_enable(rob_write_enable),
		.rob_dest(rob_dest),
		.rob_value(rob_value),
		.reg_dest(reg_dest),
		.ld_reg_busy_dest(ld_reg_busy_dest),
		.reg_rob_entry(reg_rob_entry),
		.pcmux_sel(pcmux_sel),
		.br_pc(br_pc)
	);

endmodule

// ==== hdl/operand_if.sv ====
`timescale 1ns/1ps

interface operand_if;

	// Lookup side
	tomasulo_pkg::reg_lookup_t lookup;
	logic rob_valid;
	isa_pkg::word_t rob_value;

	// Resolved side
	isa_pkg::word_t value;
	logic ready;
	tomasulo_pkg::rob_tag_t tag;    // Producer to wait on when not ready

	modport resolver
	(
		input lookup, rob_valid, rob_value,
		output value, ready, tag
	);

	modport consumer
	(
		input value, ready, tag
	);

endinterface

// ==== hdl/operand_resolver.sv ====
`timescale 1ns/1ps

module operand_resolver
(
	operand_if.resolver opnd,
	input tomasulo_pkg::cdb_t cdb
);
	import tomasulo_pkg::*;

	rob_tag_t entry;
	logic cdb_hit;

	assign entry = opnd.lookup.rob_entry;
	assign cdb_hit = cdb.valid && (cdb.tag == entry); // Catch a result on the bus this cycle

	always_comb
	begin
		opnd.value = '0;
		opnd.ready = 1'b0;
		opnd.tag = '0;
		if (!opnd.lookup.busy)
		begin
			opnd.value = opnd.lookup.data;
			opnd.ready = 1'b1;
		end
		else if (cdb_hit)
		begin
			opnd.value = cdb.data;
			opnd.ready = 1'b1;
		end
		else if (opnd.rob_valid)
		begin
			// Done but not yet committed
			opnd.value = opnd.rob_value;
			opnd.ready = 1'b1;
		end
		else
		begin
			opnd.tag = entry;
		end
	end

endmodule

// ==== hdl/tomasulo_pkg.sv ====
package tomasulo_pkg;

	localparam int num_alu_stations = 3;

	typedef logic [2:0] rob_tag_t;
	typedef logic [$clog2(num_alu_stations)-1:0] station_id_t;

	// One broadcast per cycle
	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		isa_pkg::word_t data;
	} cdb_t;

	// Register file read port result
	typedef struct packed {
		logic busy;             // Value still owned by a ROB entry
		isa_pkg::word_t data;
		rob_tag_t rob_entry;
	} reg_lookup_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Compile and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing -f src.f --top-module issue_stage_tb -Mdir "$obj" -o issue_stage_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$obj/issue_stage_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1

// ==== src.f ====
hdl/isa_pkg.sv
hdl/tomasulo_pkg.sv
hdl/operand_if.sv
hdl/operand_resolver.sv
hdl/issue_sequencer.sv
hdl/dispatch_router.sv
hdl/issue_stage.sv
tests/issue_checker.sv
tests/issue_stage_tb.sv

// ==== tests/issue_checker.sv ====
`timescale 1ns/1ps

module issue_checker
#(
	parameter int n_fields = 33,
	parameter int sample_delay = 36     // Just before the next rising edge
)
(
	input logic clk,
	input logic row_valid,
	input logic done,
	input int test_num,
	input logic [15:0] exp_vals [n_fields],
	input logic [n_fields-1:0] care_mask,
	output int error_count,
	input logic stall,
	input logic ldstr_write_enable,
	input logic rob_write_enable,
	input logic ld_reg_busy_dest,
	input logic issue_ld_busy_dest,
	input tomasulo_pkg::station_id_t res_station_id,
	input isa_pkg::word_t res_vj,
	input isa_pkg::word_t res_vk,
	input tomasulo_pkg::rob_tag_t res_qj,
	input logic issue_ld_vj,
	input logic issue_ld_vk,
	input logic issue_ld_qj,
	input tomasulo_pkg::rob_tag_t reg_rob_entry,
	input isa_pkg::word_t ldstr_offset,
	input tomasulo_pkg::rob_tag_t ldstr_dest,
	input isa_pkg::word_t ldstr_vbase,
	input tomasulo_pkg::rob_tag_t ldstr_qbase,
	input isa_pkg::word_t ldstr_vsrc,
	input isa_pkg::reg_idx_t rob_dest,
	input isa_pkg::word_t rob_value,
	input logic pcmux_sel,
	input isa_pkg::word_t br_pc,
	input isa_pkg::opcode_t res_op,
	input tomasulo_pkg::rob_tag_t res_qk,
	input logic issue_ld_qk,
	input logic ldstr_vbase_valid,
	input logic ldstr_vsrc_valid,
	input tomasulo_pkg::rob_tag_t ldstr_qsrc,
	input isa_pkg::reg_idx_t reg_dest,
	input isa_pkg::reg_idx_t sr1,
	input isa_pkg::reg_idx_t sr2,
	input tomasulo_pkg::rob_tag_t rob_sr1_read_addr,
	input tomasulo_pkg::rob_tag_t rob_sr2_read_addr
);
	logic [15:0] act [n_fields];
	string names [n_fields] = '{"stall", "ldstr_write_enable", "rob_write_enable",
		"ld_reg_busy_dest", "issue_ld_busy_dest", "res_station_id", "res_vj", "res_vk",
		"res_qj", "issue_ld_vj", "issue_ld_vk", "issue_ld_qj", "reg_rob_entry",
		"ldstr_offset", "ldstr_dest", "ldstr_vbase", "ldstr_qbase", "ldstr_vsrc",
		"rob_dest", "rob_value", "pcmux_sel", "br_pc", "res_op", "res_qk",
		"issue_ld_qk", "ldstr_vbase_valid", "ldstr_vsrc_valid", "ldstr_qsrc",
		"reg_dest", "sr1", "sr2", "rob_sr1_read_addr", "rob_sr2_read_addr"};
	int cur_test;
	int test_errs;
	int tests_run;
	int tests_failed;
	logic have_test;

	initial
	begin
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		test_errs = 0;
		cur_test = 0;
		have_test = 1'b0;
	end

	// Same order as the field list in the testbench
	always_comb
	begin
		act = '{16'(stall), 16'(ldstr_write_enable), 16'(rob_write_enable),
			16'(ld_reg_busy_dest), 16'(issue_ld_busy_dest), 16'(res_station_id),
			res_vj, res_vk, 16'(res_qj), 16'(issue_ld_vj), 16'(issue_ld_vk),
			16'(issue_ld_qj), 16'(reg_rob_entry), ldstr_offset, 16'(ldstr_dest),
			ldstr_vbase, 16'(ldstr_qbase), ldstr_vsrc, 16'(rob_dest), rob_value,
			16'(pcmux_sel), br_pc, 16'(res_op), 16'(res_qk), 16'(issue_ld_qk),
			16'(ldstr_vbase_valid), 16'(ldstr_vsrc_valid), 16'(ldstr_qsrc),
			16'(reg_dest), 16'(sr1), 16'(sr2), 16'(rob_sr1_read_addr),
			16'(rob_sr2_read_addr)};
	end

	task automatic end_test();
		if (test_errs == 0)
			$display("test %0d: ok", cur_test);
		else
		begin
			$display("test %0d: %0d mismatches", cur_test, test_errs);
			tests_failed++;
		end
		tests_run++;
	endtask

	always @(posedge clk)
	begin
		#sample_delay;
		if (row_valid)
		begin
			if (!have_test || test_num != cur_test)
			begin
				if (have_test)
					end_test();
				cur_test = test_num;
				test_errs = 0;
				have_test = 1'b1;
			end
			for (int f = 0; f < n_fields; f++)
			begin
				if (care_mask[f] && act[f] !== exp_vals[f])
				begin
					$display("[FAIL] test %0d: %s expected %h, got %h",
						test_num, names[f], exp_vals[f], act[f]);
					test_errs++;
					error_count++;
				end
			end
		end
	end

	always @(posedge done)
	begin
		if (have_test)
			end_test(); // Last test has no successor row
		$display("checker: %0d tests, %0d failed, %0d mismatches",
			tests_run, tests_failed, error_count);
	end

endmodule

// ==== tests/issue_stage_tb.sv ====
`timescale 1ns/1ps

module issue_stage_tb;
	import isa_pkg::*;
	import tomasulo_pkg::*;

	localparam int clk_period = 40;
	localparam int drive_delay = 2;
	localparam int max_rows = 32;

	// Checked outputs, in the checker's order
	typedef enum int {
		f_stall, f_ldstr_we, f_rob_we, f_reg_busy, f_issue_busy,
		f_station, f_vj, f_vk, f_qj, f_ld_vj, f_ld_vk, f_ld_qj,
		f_reg_rob_entry, f_offset, f_ldstr_dest, f_vbase, f_qbase,
		f_vsrc, f_rob_dest, f_rob_value, f_pcmux, f_br_pc, f_res_op,
		f_qk, f_ld_qk, f_vbase_valid, f_vsrc_valid, f_qsrc, f_reg_dest,
		f_sr1, f_sr2, f_rob_rd1, f_rob_rd2, n_fields
	} field_t;

	typedef struct packed {
		logic [15:0] instr;
		logic instr_is_new;
		logic flush;
		word_t curr_pc;
		logic predict_bit;
		cdb_t cdb_in;
		logic [num_alu_stations-1:0] alu_busy;
		logic ldstr_full;
		logic rob_full;
		rob_tag_t rob_addr;
		word_t rob_sr1_value;
		logic rob_sr1_valid;
		word_t rob_sr2_value;
		logic rob_sr2_valid;
		reg_lookup_t sr1_in;
		reg_lookup_t sr2_in;
		reg_lookup_t dest_in;
	} stim_t;

	logic clk = 1'b0;
	logic rst;
	logic flush, instr_is_new, predict_bit, ldstr_full, rob_full;
	logic rob_sr1_valid, rob_sr2_valid;
	instr_u instr;
	word_t curr_pc, rob_sr1_value, rob_sr2_value;
	cdb_t cdb_in;
	logic [num_alu_stations-1:0] alu_busy;
	rob_tag_t rob_addr;
	reg_lookup_t sr1_in, sr2_in, dest_in;
	logic stall, pcmux_sel;
	word_t br_pc, res_vj, res_vk, ldstr_offset, ldstr_vbase, ldstr_vsrc, rob_value;
	station_id_t res_station_id;
	opcode_t res_op;
	rob_tag_t res_qj, res_qk, ldstr_qbase, ldstr_qsrc, ldstr_dest, reg_rob_entry;
	rob_tag_t rob_sr1_read_addr, rob_sr2_read_addr;
	logic issue_ld_vj, issue_ld_vk, issue_ld_qj, issue_ld_qk, issue_ld_busy_dest;
	logic ldstr_write_enable, ldstr_vbase_valid, ldstr_vsrc_valid;
	logic rob_write_enable, ld_reg_busy_dest;
	reg_idx_t rob_dest, reg_dest, sr1, sr2;

	// Checker side
	logic row_valid;
	logic done;
	int test_num;
	logic [15:0] exp_vals [n_fields];
	logic [n_fields-1:0] care_mask;
	int error_count;

	stim_t stim_tab [max_rows];
	logic [15:0] exp_tab [max_rows][n_fields];
	logic [n_fields-1:0] care_tab [max_rows];
	int test_tab [max_rows];
	int n_rows;
	int seed;
	logic table_ready;
	stim_t cur;                         // Row under construction
	logic [15:0] cur_exp [n_fields];
	logic [n_fields-1:0] cur_care;

	issue_stage i_issue_stage (.*);
	issue_checker #(.n_fields(n_fields)) i_checker (.*);

	always #(clk_period / 2) clk = ~clk;

	function automatic logic [15:0] sext(input logic [15:0] v, input int bits);
		logic [15:0] r;
		r = v;
		for (int i = bits; i < 16; i++)
			r[i] = v[bits-1];
		return r;
	endfunction

	// Word offsets are shifted left one
	function automatic logic [15:0] adj(input logic [15:0] v, input int bits);
		return sext(v, bits) << 1;
	endfunction

	function automatic logic [15:0] enc_opr(input opcode_t op, input logic [2:0] dr,
		input logic [2:0] src, input logic imm, input logic [4:0] low5);
		return {op, dr, src, imm, low5};
	endfunction

	function automatic logic [15:0] enc_off(input opcode_t op, input logic [2:0] dr,
		input logic [8:0] off9);
		return {op, dr, off9};
	endfunction

	task automatic blank_row();
		cur = '0;
		cur.instr_is_new = 1'b1;
		cur.rob_addr = 3'd4;
		cur.curr_pc = 16'($random(seed));
		cur.cdb_in.data = 16'($random(seed));
		cur.rob_sr1_value = 16'($random(seed));
		cur.rob_sr2_value = 16'($random(seed));
		cur.sr1_in.data = 16'($random(seed));
		cur.sr2_in.data = 16'($random(seed));
		cur.dest_in.data = 16'($random(seed));
		cur_care = '0;
		foreach (cur_exp[f])
			cur_exp[f] = '0;
	endtask

	task automatic want(input field_t f, input logic [15:0] v);
		cur_exp[f] = v;
		cur_care[f] = 1'b1;
	endtask

	// No write of any kind this cycle
	task automatic want_quiet(input logic stall_v);
		want(f_stall, 16'(stall_v));
		want(f_ldstr_we, 16'd0);
		want(f_rob_we, 16'd0);
		want(f_reg_busy, 16'd0);
		want(f_issue_busy, 16'd0);
		want(f_pcmux, 16'd0);
	endtask

	task automatic commit_row(input int test);
		stim_tab[n_rows] = cur;
		exp_tab[n_rows] = cur_exp;
		care_tab[n_rows] = cur_care;
		test_tab[n_rows] = test;
		n_rows++;
		blank_row();
	endtask

	task automatic fill_table();
		logic [15:0] ins;
		blank_row();
		// ADD imm5 goes to the one free station
		cur.instr = enc_opr(op_add, 3'd2, 3'd1, 1'b1, 5'b10011);
		cur.alu_busy = 3'b011;
		want(f_station, 16'd2);
		want(f_res_op, 16'(op_add));
		want(f_vj, cur.sr1_in.data);
		want(f_vk, sext(16'b10011, 5));
		want(f_ld_vj, 16'd1);
		want(f_ld_vk, 16'd1);
		want(f_rob_we, 16'd1);
		want(f_reg_busy, 16'd1);
		want(f_issue_busy, 16'd1);
		want(f_reg_rob_entry, 16'd4);
		want(f_rob_dest, 16'd2);
		want(f_reg_dest, 16'd2);
		want(f_sr1, 16'd1);
		want(f_stall, 16'd0);
		commit_row(1);
		// sr1 busy: CDB beats ROB, then ROB, then wait on the tag
		for (int k = 0; k < 3; k++)
		begin
			cur.instr = enc_opr(op_add, 3'd3, 3'd1, 1'b0, 5'd2);
			cur.sr1_in.busy = 1'b1;
			cur.sr1_in.rob_entry = 3'd6;
			cur.sr2_in.busy = (k == 2);
			cur.sr2_in.rob_entry = 3'd5;
			cur.rob_sr1_valid = (k < 2);
			cur.cdb_in.valid = (k < 2);
			cur.cdb_in.tag = (k == 1) ? 3'd2 : 3'd6;
			want(f_vk, (k == 2) ? 16'd0 : cur.sr2_in.data);
			want(f_ld_vk, 16'(k < 2));
			want(f_ld_qk, 16'(k == 2));
			want(f_qk, (k == 2) ? 16'd5 : 16'd0);
			want(f_ld_vj, 16'(k < 2));
			want(f_ld_qj, 16'(k == 2));
			want(f_qj, (k == 2) ? 16'd6 : 16'd0);
			want(f_vj, (k == 0) ? cur.cdb_in.data : (k == 1) ? cur.rob_sr1_value : 16'd0);
			want(f_sr1, 16'd1);
			want(f_sr2, 16'd2);
			want(f_rob_rd1, 16'd6);
			want(f_rob_rd2, 16'd5);
			commit_row(2);
		end
		cur.instr = enc_opr(op_add, 3'd1, 3'd2, 1'b1, 5'd1);
		cur.rob_full = 1'b1;
		want_quiet(1'b1);
		commit_row(3);
		cur.instr = enc_opr(op_and, 3'd1, 3'd2, 1'b1, 5'd1);
		cur.alu_busy = 3'b111;
		want_quiet(1'b1);
		commit_row(3);
		cur.instr = enc_off(op_ldr, 3'd1, 9'h041);
		cur.ldstr_full = 1'b1;
		want_quiet(1'b1);
		commit_row(3);
		cur.instr = enc_opr(op_not, 3'd1, 3'd2, 1'b1, 5'h1f);
		cur.alu_busy = 3'b111;
		want_quiet(1'b1);
		commit_row(3);
		// NOT needs a station, not the load/store buffer
		cur.instr = enc_opr(op_not, 3'd1, 3'd2, 1'b1, 5'h1f);
		cur.ldstr_full = 1'b1;
		cur.alu_busy = 3'b001;
		want(f_stall, 16'd0);
		want(f_station, 16'd1);
		want(f_res_op, 16'(op_not));
		want(f_rob_we, 16'd1);
		want(f_ldstr_we, 16'd0);
		commit_row(3);
		// LDR base from a finished ROB entry
		cur.instr = enc_off(op_ldr, 3'd4, {3'd1, 6'b111010});
		cur.sr1_in.busy = 1'b1;
		cur.sr1_in.rob_entry = 3'd3;
		cur.rob_sr1_valid = 1'b1;
		cur.rob_addr = 3'd1;
		want(f_offset, adj(16'b111010, 6));
		want(f_ldstr_dest, 16'd1);
		want(f_vbase, cur.rob_sr1_value);
		want(f_vbase_valid, 16'd1);
		want(f_qbase, 16'd0);
		want(f_ldstr_we, 16'd1);
		want(f_rob_we, 16'd1);
		want(f_reg_busy, 16'd1);
		want(f_rob_dest, 16'd4);
		want(f_reg_dest, 16'd4);
		want(f_sr1, 16'd1);
		want(f_rob_rd1, 16'd3);
		commit_row(4);
		cur.instr = enc_off(op_str, 3'd5, {3'd2, 6'b000111});
		cur.sr2_in.busy = 1'b1;         // Must not be used for store data
		cur.sr2_in.rob_entry = 3'd2;
		cur.dest_in.rob_entry = 3'd5;
		cur.rob_addr = 3'd3;
		want(f_offset, adj(16'b000111, 6));
		want(f_vsrc, cur.dest_in.data);
		want(f_vsrc_valid, 16'd1);
		want(f_qsrc, 16'd0);
		want(f_rob_rd2, 16'd5);
		want(f_vbase, cur.sr1_in.data);
		want(f_ldstr_dest, 16'd0);
		want(f_rob_dest, 16'd0);
		want(f_reg_busy, 16'd0);
		want(f_ldstr_we, 16'd1);
		want(f_rob_we, 16'd1);
		commit_row(4);
		cur.instr = enc_off(op_br, 3'd7, 9'h1f0);
		cur.predict_bit = 1'b1;
		want(f_br_pc, cur.curr_pc + adj(16'h1f0, 9));
		want(f_pcmux, 16'd1);
		want(f_rob_value, cur.curr_pc);
		want(f_rob_we, 16'd1);
		want(f_stall, 16'd0);
		commit_row(5);
		cur.instr = enc_opr(op_add, 3'd1, 3'd1, 1'b1, 5'd3);
		want_quiet(1'b0);               // Bubble slot
		commit_row(5);
		cur.instr = enc_off(op_br, 3'd2, 9'h025);
		want(f_br_pc, cur.curr_pc + adj(16'h025, 9));
		want(f_rob_value, cur.curr_pc + adj(16'h025, 9));
		want(f_pcmux, 16'd0);
		commit_row(5);
		cur.instr = enc_off(op_lea, 3'd6, 9'h155);
		want(f_rob_value, cur.curr_pc + adj(16'h155, 9));
		want(f_rob_we, 16'd1);
		want(f_reg_busy, 16'd1);
		want(f_rob_dest, 16'd6);
		want(f_reg_dest, 16'd6);
		commit_row(5);
		// LDI, first waiting on the pointer tag, then caught on the CDB
		ins = enc_off(op_ldi, 3'd7, {3'd1, 6'b000011});
		for (int k = 0; k < 2; k++)
		begin
			cur.instr = ins;
			cur.rob_addr = (k == 0) ? 3'd2 : 3'd5;
			want(f_stall, 16'd1);
			want(f_offset, adj(16'b000011, 6));
			want(f_vbase, cur.sr1_in.data);
			want(f_ldstr_dest, 16'(cur.rob_addr));
			want(f_ldstr_we, 16'd1);
			want(f_rob_we, 16'd1);
			want(f_reg_busy, 16'd0);
			commit_row(6);
			if (k == 1)
			begin
				cur.instr = ins;
				cur.ldstr_full = 1'b1;  // Pass 2 must hold
				want_quiet(1'b1);
				commit_row(6);
			end
			cur.instr = ins;
			cur.rob_addr = (k == 0) ? 3'd3 : 3'd6;
			cur.cdb_in.valid = (k == 1);
			cur.cdb_in.tag = 3'd5;
			want(f_stall, 16'd0);
			want(f_offset, 16'd0);
			want(f_qbase, (k == 0) ? 16'd2 : 16'd0);
			want(f_vbase, (k == 0) ? 16'd0 : cur.cdb_in.data);
			want(f_vbase_valid, 16'(k == 1));
			want(f_reg_busy, 16'd1);
			want(f_reg_dest, 16'd7);
			want(f_reg_rob_entry, 16'(cur.rob_addr));
			want(f_ldstr_dest, 16'(cur.rob_addr));
			commit_row(6);
		end
		// Flush drops a pending LDI pass 2
		cur.instr = enc_off(op_ldi, 3'd3, {3'd4, 6'b000001});
		want(f_stall, 16'd1);
		commit_row(7);
		cur.flush = 1'b1;
		cur.instr_is_new = 1'b0;
		want_quiet(1'b0);
		commit_row(7);
		cur.instr = enc_off(op_ldi, 3'd3, {3'd4, 6'b000001});
		want(f_stall, 16'd1);
		want(f_offset, adj(16'b000001, 6));
		commit_row(7);
	endtask

	task automatic drive_inputs(input stim_t s);
		instr = s.instr;
		instr_is_new = s.instr_is_new;
		flush = s.flush;
		curr_pc = s.curr_pc;
		predict_bit = s.predict_bit;
		cdb_in = s.cdb_in;
		alu_busy = s.alu_busy;
		ldstr_full = s.ldstr_full;
		rob_full = s.rob_full;
		rob_addr = s.rob_addr;
		rob_sr1_value = s.rob_sr1_value;
		rob_sr1_valid = s.rob_sr1_valid;
		rob_sr2_value = s.rob_sr2_value;
		rob_sr2_valid = s.rob_sr2_valid;
		sr1_in = s.sr1_in;
		sr2_in = s.sr2_in;
		dest_in = s.dest_in;
	endtask

	task automatic apply_row(input int i);
		drive_inputs(stim_tab[i]);
		exp_vals = exp_tab[i];
		care_mask = care_tab[i];
		test_num = test_tab[i];
		row_valid = 1'b1;
	endtask

	initial
	begin
		seed = 32'hb491;
		n_rows = 0;
		table_ready = 1'b0;
		rst = 1'b1;
		drive_inputs('0);
		row_valid = 1'b0;
		done = 1'b0;
		test_num = 0;
		care_mask = '0;
		foreach (exp_vals[f])
			exp_vals[f] = '0;
		fill_table();
		table_ready = 1'b1;
		repeat (4) @(posedge clk);
		#drive_delay;
		rst = 1'b0;
		for (int i = 0; i < n_rows; i++)
		begin
			apply_row(i);
			@(posedge clk);
			#drive_delay;
		end
		drive_inputs('0);
		row_valid = 1'b0;
		done = 1'b1;
		#1;
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Reset plus one cycle per row fits well inside the margin
	initial
	begin
		wait (table_ready);
		#((n_rows + 10) * clk_period);
		$display("Timeout: stimulus did not finish within %0d cycles", n_rows + 10);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule
